/* src/vertex_job_pkg.sv */
////////////////////////////////////////////////////////////
// shared types for the vertex job control unit
// widths, array field tags, FSM states and the structs that
// travel on the descriptor, command and job ports
////////////////////////////////////////////////////////////

package vertex_job_pkg;

	////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////

	localparam int VERTEX_W   = 32;
	localparam int ADDR_W     = 32;
	// bytes in one vertex word of a memory line
	localparam int WORD_BYTES = 4;

	typedef logic [VERTEX_W-1:0] vertex_word_t;
	typedef logic [VERTEX_W-1:0] vertex_id_t;
	typedef logic [ADDR_W-1:0]   addr_t;

	////////////////////////////////////////////////////////////
	// enums
	////////////////////////////////////////////////////////////

	// array a read command or returned line belongs to
	typedef enum logic [1:0] {
		OUT_DEGREE     = 2'd0,
		EDGES_IDX      = 2'd1,
		INV_OUT_DEGREE = 2'd2
	} vertex_field_e;

	typedef enum logic [2:0] {
		IDLE,
		WAIT_UNPACKER,
		SEND_OUT_DEGREE,
		SEND_EDGES_IDX,
		SEND_INV_OUT_DEGREE,
		ADVANCE
	} seq_state_e;

	typedef enum logic {
		COLLECT,
		EMIT
	} unpack_state_e;

	////////////////////////////////////////////////////////////
	// structs
	////////////////////////////////////////////////////////////

	typedef struct packed {
		vertex_id_t num_vertices;
		addr_t      out_degree_base;
		addr_t      edges_idx_base;
		addr_t      inv_out_degree_base;
	} graph_desc_t;

	// one line read, count is the number of valid vertices in it
	typedef struct packed {
		addr_t         addr;
		vertex_field_e field;
		logic [7:0]    count;
	} read_cmd_t;

	typedef struct packed {
		vertex_id_t   id;
		vertex_word_t out_degree;
		vertex_word_t edges_idx;
		vertex_word_t inv_out_degree;
	} vertex_job_t;

endpackage

/* src/vertex_read_sequencer.sv */
////////////////////////////////////////////////////////////
// takes one graph descriptor and walks its vertex arrays
// one batch of up to LINE_VERTICES vertices at a time,
// issuing one line read per array once the unpacker is idle
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module vertex_read_sequencer #(
	parameter int LINE_VERTICES = 4
) (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        desc_valid,
	output logic                        desc_ready,
	input  vertex_job_pkg::graph_desc_t desc,
	input  logic                        unpacker_idle,
	output logic                        batch_start,
	output logic [7:0]                  batch_count,
	output logic                        cmd_valid,
	input  logic                        cmd_ready,
	output vertex_job_pkg::read_cmd_t   cmd
);

	vertex_job_pkg::seq_state_e  state, state_next;
	vertex_job_pkg::graph_desc_t desc_q;
	vertex_job_pkg::vertex_id_t  remaining;
	vertex_job_pkg::addr_t       offset;
	logic [7:0]                  count_q;

	assign desc_ready = (state == vertex_job_pkg::IDLE);
	assign cmd_valid  = (state == vertex_job_pkg::SEND_OUT_DEGREE) ||
		(state == vertex_job_pkg::SEND_EDGES_IDX) ||
		(state == vertex_job_pkg::SEND_INV_OUT_DEGREE);

	// partial batch at the tail of the array
	assign batch_count = (remaining > vertex_job_pkg::vertex_id_t'(LINE_VERTICES)) ?
		8'(LINE_VERTICES) : remaining[7:0];
	assign batch_start = (state == vertex_job_pkg::WAIT_UNPACKER) && unpacker_idle &&
		(remaining != '0);

	////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			vertex_job_pkg::IDLE: begin
				if (desc_valid)
					state_next = vertex_job_pkg::WAIT_UNPACKER;
			end
			vertex_job_pkg::WAIT_UNPACKER: begin
				if (remaining == '0)
					state_next = vertex_job_pkg::IDLE;
				else if (unpacker_idle)
					state_next = vertex_job_pkg::SEND_OUT_DEGREE;
			end
			vertex_job_pkg::SEND_OUT_DEGREE: begin
				if (cmd_ready)
					state_next = vertex_job_pkg::SEND_EDGES_IDX;
			end
			vertex_job_pkg::SEND_EDGES_IDX: begin
				if (cmd_ready)
					state_next = vertex_job_pkg::SEND_INV_OUT_DEGREE;
			end
			vertex_job_pkg::SEND_INV_OUT_DEGREE: begin
				if (cmd_ready)
					state_next = vertex_job_pkg::ADVANCE;
			end
			vertex_job_pkg::ADVANCE: begin
				if (remaining == vertex_job_pkg::vertex_id_t'(count_q))
					state_next = vertex_job_pkg::IDLE;
				else
					state_next = vertex_job_pkg::WAIT_UNPACKER;
			end
			default: state_next = vertex_job_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state     <= vertex_job_pkg::IDLE;
			remaining <= '0;
			offset    <= '0;
			count_q   <= '0;
		end else begin
			state <= state_next;
			if (desc_valid && desc_ready) begin
				remaining <= desc.num_vertices;
				offset    <= '0;
			end
			if (batch_start)
				count_q <= batch_count;
			if (state == vertex_job_pkg::ADVANCE) begin
				remaining <= remaining - vertex_job_pkg::vertex_id_t'(count_q);
				offset    <= offset +
					vertex_job_pkg::addr_t'(LINE_VERTICES * vertex_job_pkg::WORD_BYTES);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (desc_valid && desc_ready)
			desc_q <= desc;
	end

	////////////////////////////////////////////////////////////
	// command payload, stable while the state waits on ready
	////////////////////////////////////////////////////////////

	always_comb begin
		cmd.count = count_q;
		case (state)
			vertex_job_pkg::SEND_EDGES_IDX: begin
				cmd.addr  = desc_q.edges_idx_base + offset;
				cmd.field = vertex_job_pkg::EDGES_IDX;
			end
			vertex_job_pkg::SEND_INV_OUT_DEGREE: begin
				cmd.addr  = desc_q.inv_out_degree_base + offset;
				cmd.field = vertex_job_pkg::INV_OUT_DEGREE;
			end
			default: begin
				cmd.addr  = desc_q.out_degree_base + offset;
				cmd.field = vertex_job_pkg::OUT_DEGREE;
			end
		endcase
	end

endmodule

/* src/vertex_line_unpacker.sv */
////////////////////////////////////////////////////////////
// collects the three lines of a batch in any order, then
// walks them one vertex per cycle; vertices with a zero
// inverse out degree are dropped and counted
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module vertex_line_unpacker #(
	parameter int LINE_VERTICES = 4
) (
	input  logic                                             clock,
	input  logic                                             rstn,
	input  logic                                             batch_start,
	input  logic [7:0]                                       batch_count,
	input  logic                                             rd_valid,
	input  vertex_job_pkg::vertex_field_e                    rd_field,
	input  vertex_job_pkg::vertex_word_t [LINE_VERTICES-1:0] rd_line,
	output logic                                             unpacker_idle,
	output logic                                             push_valid,
	input  logic                                             push_ready,
	output vertex_job_pkg::vertex_job_t                      push_job,
	output vertex_job_pkg::vertex_id_t                       filtered_count
);

	vertex_job_pkg::unpack_state_e state;
	vertex_job_pkg::vertex_word_t [LINE_VERTICES-1:0] line_q [0:2];
	logic [2:0]                    arrived, arrived_next;
	logic                          busy;
	logic [7:0]                    count_q;
	logic [7:0]                    idx;
	vertex_job_pkg::vertex_id_t    next_id;
	logic                          keep;
	logic                          step;
	logic                          last;

	assign unpacker_idle = !busy;

	always_comb begin
		arrived_next = arrived;
		if (rd_valid)
			arrived_next[rd_field] = 1'b1;
	end

	// line registers, one per array, picked by the field tag
	always_ff @(posedge clock) begin
		if (rd_valid)
			line_q[rd_field] <= rd_line;
	end

	////////////////////////////////////////////////////////////
	// vertex assembly
	////////////////////////////////////////////////////////////

	always_comb begin
		push_job.id             = next_id;
		push_job.out_degree     = line_q[vertex_job_pkg::OUT_DEGREE][idx];
		push_job.edges_idx      = line_q[vertex_job_pkg::EDGES_IDX][idx];
		push_job.inv_out_degree = line_q[vertex_job_pkg::INV_OUT_DEGREE][idx];
	end

	assign keep       = (push_job.inv_out_degree != '0);
	assign push_valid = (state == vertex_job_pkg::EMIT) && keep;
	// a filtered vertex never waits on the queue
	assign step       = (state == vertex_job_pkg::EMIT) && (!keep || push_ready);
	assign last       = (idx == count_q - 8'd1);

	////////////////////////////////////////////////////////////
	// control
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state          <= vertex_job_pkg::COLLECT;
			arrived        <= '0;
			busy           <= 1'b0;
			count_q        <= '0;
			idx            <= '0;
			next_id        <= '0;
			filtered_count <= '0;
		end else begin
			if (batch_start) begin
				busy    <= 1'b1;
				count_q <= batch_count;
			end
			case (state)
				vertex_job_pkg::COLLECT: begin
					arrived <= arrived_next;
					// start emitting the cycle after the third line lands
					if (busy && (arrived_next == 3'b111))
						state <= vertex_job_pkg::EMIT;
				end
				vertex_job_pkg::EMIT: begin
					if (step) begin
						next_id <= next_id + 1'b1;
						if (!keep)
							filtered_count <= filtered_count + 1'b1;
						if (last) begin
							state   <= vertex_job_pkg::COLLECT;
							busy    <= 1'b0;
							arrived <= '0;
							idx     <= '0;
						end else begin
							idx <= idx + 8'd1;
						end
					end
				end
				default: state <= vertex_job_pkg::COLLECT;
			endcase
		end
	end

endmodule

/* src/vertex_job_queue.sv */
////////////////////////////////////////////////////////////
// circular FIFO of vertex jobs, valid/ready on both sides
// JOB_DEPTH must be a power of two
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module vertex_job_queue #(
	parameter int JOB_DEPTH = 8
) (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        push_valid,
	output logic                        push_ready,
	input  vertex_job_pkg::vertex_job_t push_job,
	output logic                        job_valid,
	input  logic                        job_ready,
	output vertex_job_pkg::vertex_job_t job
);

	localparam int PTR_W = $clog2(JOB_DEPTH);

	vertex_job_pkg::vertex_job_t mem [JOB_DEPTH];
	logic [PTR_W-1:0]            wr_ptr;
	logic [PTR_W-1:0]            rd_ptr;
	logic [PTR_W:0]              occupancy;
	logic                        do_push;
	logic                        do_pop;

	assign push_ready = (occupancy != (PTR_W+1)'(JOB_DEPTH));
	assign job_valid  = (occupancy != '0);
	assign job        = mem[rd_ptr];
	assign do_push    = push_valid && push_ready;
	assign do_pop     = job_valid && job_ready;

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= push_job;
	end

	// pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			occupancy <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				occupancy <= occupancy + 1'b1;
			else if (do_pop && !do_push)
				occupancy <= occupancy - 1'b1;
		end
	end

endmodule

/* src/vertex_job_control.sv */
////////////////////////////////////////////////////////////
// vertex job control top level
// sequencer issues line reads, unpacker turns returned lines
// into vertex jobs, queue hands them to the compute unit
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module vertex_job_control #(
	parameter int LINE_VERTICES = 4,
	parameter int JOB_DEPTH     = 8
) (
	input  logic                                             clock,
	input  logic                                             rstn,
	// descriptor
	input  logic                                             desc_valid,
	output logic                                             desc_ready,
	input  vertex_job_pkg::graph_desc_t                      desc,
	// memory read commands
	output logic                                             cmd_valid,
	input  logic                                             cmd_ready,
	output vertex_job_pkg::read_cmd_t                        cmd,
	// returned lines
	input  logic                                             rd_valid,
	input  vertex_job_pkg::vertex_field_e                    rd_field,
	input  vertex_job_pkg::vertex_word_t [LINE_VERTICES-1:0] rd_line,
	// jobs to the compute unit
	output logic                                             job_valid,
	input  logic                                             job_ready,
	output vertex_job_pkg::vertex_job_t                      job,
	output vertex_job_pkg::vertex_id_t                       filtered_count
);

	logic                        batch_start;
	logic [7:0]                  batch_count;
	logic                        unpacker_idle;
	logic                        push_valid;
	logic                        push_ready;
	vertex_job_pkg::vertex_job_t push_job;

	vertex_read_sequencer #(
		.LINE_VERTICES(LINE_VERTICES)
	) u_sequencer (
		.clock        (clock),
		.rstn         (rstn),
		.desc_valid   (desc_valid),
		.desc_ready   (desc_ready),
		.desc         (desc),
		.unpacker_idle(unpacker_idle),
		.batch_start  (batch_start),
		.batch_count  (batch_count),
		.cmd_valid    (cmd_valid),
		.cmd_ready    (cmd_ready),
		.cmd          (cmd)
	);

	vertex_line_unpacker #(
		.LINE_VERTICES(LINE_VERTICES)
	) u_unpacker (
		.clock         (clock),
		.rstn          (rstn),
		.batch_start   (batch_start),
		.batch_count   (batch_count),
		.rd_valid      (rd_valid),
		.rd_field      (rd_field),
		.rd_line       (rd_line),
		.unpacker_idle (unpacker_idle),
		.push_valid    (push_valid),
		.push_ready    (push_ready),
		.push_job      (push_job),
		.filtered_count(filtered_count)
	);

	vertex_job_queue #(
		.JOB_DEPTH(JOB_DEPTH)
	) u_queue (
		.clock     (clock),
		.rstn      (rstn),
		.push_valid(push_valid),
		.push_ready(push_ready),
		.push_job  (push_job),
		.job_valid (job_valid),
		.job_ready (job_ready),
		.job       (job)
	);

endmodule

/* bench/vertex_job_assert.sv */
////////////////////////////////////////////////////////////
// concurrent checks on the command and job ports
// bound into vertex_job_control; error_seen goes high on
// the first failed check
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module vertex_job_assert #(
	parameter int LINE_VERTICES = 4
) (
	input logic                        clock,
	input logic                        rstn,
	input logic                        desc_valid,
	input logic                        desc_ready,
	input vertex_job_pkg::graph_desc_t desc,
	input logic                        cmd_valid,
	input logic                        cmd_ready,
	input vertex_job_pkg::read_cmd_t   cmd,
	input logic                        job_valid,
	input logic                        job_ready,
	input vertex_job_pkg::vertex_job_t job
);

	logic                       error_seen = 1'b0;
	vertex_job_pkg::vertex_id_t num_vertices;
	int unsigned                cmd_total;
	vertex_job_pkg::vertex_id_t exp_id;

	function automatic vertex_job_pkg::vertex_word_t inv_degree(
		input vertex_job_pkg::vertex_id_t i
	);
		return (i % 3 == 0) ? '0 : i + 7;
	endfunction

	// vertices in the batch that command n belongs to
	function automatic logic [7:0] batch_size(input int unsigned n);
		int unsigned left;
		left = num_vertices - (n / 3) * LINE_VERTICES;
		return (left > LINE_VERTICES) ? 8'(LINE_VERTICES) : left[7:0];
	endfunction

	always @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			num_vertices <= '0;
			cmd_total    <= 0;
			exp_id       <= 1;
		end else begin
			if (desc_valid && desc_ready) begin
				num_vertices <= desc.num_vertices;
				cmd_total    <= 0;
			end
			if (cmd_valid && cmd_ready)
				cmd_total <= cmd_total + 1;
			// next kept id skips multiples of three
			if (job_valid && job_ready)
				exp_id <= (job.id % 3 == 2) ? job.id + 2 : job.id + 1;
		end
	end

	////////////////////////////////////////////////////////////
	// properties
	////////////////////////////////////////////////////////////

	cmd_hold: assert property (@(posedge clock) disable iff (!rstn)
		(cmd_valid && !cmd_ready) |=> (cmd_valid && $stable(cmd)))
		else begin
			error_seen = 1'b1;
			$error("command dropped or changed while waiting for cmd_ready");
		end

	job_hold: assert property (@(posedge clock) disable iff (!rstn)
		(job_valid && !job_ready) |=> (job_valid && $stable(job)))
		else begin
			error_seen = 1'b1;
			$error("job dropped or changed while waiting for job_ready");
		end

	job_data: assert property (@(posedge clock) disable iff (!rstn)
		(job_valid && job_ready) |-> ((job.out_degree == job.id + 1) &&
			(job.edges_idx == job.id * 3) &&
			(job.inv_out_degree == inv_degree(job.id)) && (job.inv_out_degree != '0)))
		else begin
			error_seen = 1'b1;
			$error("Error: job.id 0x%h out_degree 0x%h edges_idx 0x%h inv_out_degree 0x%h",
				$sampled(job.id), $sampled(job.out_degree), $sampled(job.edges_idx),
				$sampled(job.inv_out_degree));
		end

	job_order: assert property (@(posedge clock) disable iff (!rstn)
		(job_valid && job_ready) |-> (job.id == exp_id))
		else begin
			error_seen = 1'b1;
			$error("Error: job.id 0x%h, expected 0x%h", $sampled(job.id), $sampled(exp_id));
		end

	cmd_rule: assert property (@(posedge clock) disable iff (!rstn)
		(cmd_valid && cmd_ready) |->
			((cmd.field == vertex_job_pkg::vertex_field_e'(cmd_total % 3)) &&
			(cmd.count == batch_size(cmd_total))))
		else begin
			error_seen = 1'b1;
			$error("Error: cmd.field 0x%h cmd.count 0x%h, expected 0x%h 0x%h",
				$sampled(cmd.field), $sampled(cmd.count), $sampled(cmd_total) % 3,
				batch_size($sampled(cmd_total)));
		end

	reset_quiet: assert property (@(posedge clock)
		!rstn |-> (!cmd_valid && !job_valid))
		else begin
			error_seen = 1'b1;
			$error("cmd_valid or job_valid high while in reset");
		end

endmodule

bind vertex_job_control vertex_job_assert #(
	.LINE_VERTICES(LINE_VERTICES)
) u_assert (
	.clock     (clock),
	.rstn      (rstn),
	.desc_valid(desc_valid),
	.desc_ready(desc_ready),
	.desc      (desc),
	.cmd_valid (cmd_valid),
	.cmd_ready (cmd_ready),
	.cmd       (cmd),
	.job_valid (job_valid),
	.job_ready (job_ready),
	.job       (job)
);

/* bench/tb_clock_gen.sv */
////////////////////////////////////////////////////////////
// testbench clock and reset source
// 4 ns clock, rstn held low for the first 10 rising edges
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock_gen (
	output logic clock,
	output logic rstn
);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	initial begin
		rstn = 1'b0;
		repeat (10) @(posedge clock);
		rstn <= 1'b1;
	end

endmodule

/* bench/tb_vertex_job_control.sv */
////////////////////////////////////////////////////////////
// testbench for the vertex job control unit
// sends one 14 vertex descriptor, models memory with random
// latency and return order, applies job back-pressure and
// checks the final filtered count; port checks are bound in
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_vertex_job_control;

	localparam int LINE_VERTICES   = 4;
	localparam int JOB_DEPTH       = 8;
	localparam int NUM_VERTICES    = 14;
	// ids 0, 3, 6, 9 and 12 carry a zero inverse out degree
	localparam int NUM_KEPT        = 9;
	localparam int EXP_FILTERED    = 5;
	localparam int STALL_CYCLES    = 80;
	localparam int WATCHDOG_CYCLES = NUM_VERTICES * 40 + 200;

	localparam vertex_job_pkg::addr_t OUT_BASE   = 32'h1000_0000;
	localparam vertex_job_pkg::addr_t EDGES_BASE = 32'h2000_0000;
	localparam vertex_job_pkg::addr_t INV_BASE   = 32'h3000_0000;

	logic                                             clock;
	logic                                             rstn;
	logic                                             desc_valid;
	logic                                             desc_ready;
	vertex_job_pkg::graph_desc_t                      desc;
	logic                                             cmd_valid;
	logic                                             cmd_ready;
	vertex_job_pkg::read_cmd_t                        cmd;
	logic                                             rd_valid;
	vertex_job_pkg::vertex_field_e                    rd_field;
	vertex_job_pkg::vertex_word_t [LINE_VERTICES-1:0] rd_line;
	logic                                             job_valid;
	logic                                             job_ready;
	vertex_job_pkg::vertex_job_t                      job;
	vertex_job_pkg::vertex_id_t                       filtered_count;

	integer                    seed;
	int                        cycle_count;
	int                        jobs_received;
	int                        pick;
	// reads in flight inside the memory model
	vertex_job_pkg::read_cmd_t pend_cmd [$];
	int                        pend_due [$];

	function automatic int rand_below(input int n);
		int r;
		r = $random(seed) & 32'h7fff_ffff;
		return r % n;
	endfunction

	function automatic vertex_job_pkg::addr_t base_of(
		input vertex_job_pkg::vertex_field_e field
	);
		case (field)
			vertex_job_pkg::OUT_DEGREE: return OUT_BASE;
			vertex_job_pkg::EDGES_IDX:  return EDGES_BASE;
			default:                    return INV_BASE;
		endcase
	endfunction

	// memory contents for vertex index i
	function automatic vertex_job_pkg::vertex_word_t memory_word(
		input vertex_job_pkg::vertex_field_e field,
		input int unsigned                   i
	);
		case (field)
			vertex_job_pkg::OUT_DEGREE: return i + 1;
			vertex_job_pkg::EDGES_IDX:  return 3 * i;
			default:                    return (i % 3 == 0) ? 0 : i + 7;
		endcase
	endfunction

	function automatic logic [LINE_VERTICES*vertex_job_pkg::VERTEX_W-1:0] line_for(
		input vertex_job_pkg::read_cmd_t c
	);
		logic [LINE_VERTICES*vertex_job_pkg::VERTEX_W-1:0] line;
		int unsigned                                       first;
		first = (c.addr - base_of(c.field)) / vertex_job_pkg::WORD_BYTES;
		for (int w = 0; w < LINE_VERTICES; w++)
			line[w*vertex_job_pkg::VERTEX_W +: vertex_job_pkg::VERTEX_W] =
				memory_word(c.field, first + w);
		return line;
	endfunction

	tb_clock_gen u_clock (
		.clock(clock),
		.rstn (rstn)
	);

	vertex_job_control #(
		.LINE_VERTICES(LINE_VERTICES),
		.JOB_DEPTH    (JOB_DEPTH)
	) DUT (
		.clock         (clock),
		.rstn          (rstn),
		.desc_valid    (desc_valid),
		.desc_ready    (desc_ready),
		.desc          (desc),
		.cmd_valid     (cmd_valid),
		.cmd_ready     (cmd_ready),
		.cmd           (cmd),
		.rd_valid      (rd_valid),
		.rd_field      (rd_field),
		.rd_line       (rd_line),
		.job_valid     (job_valid),
		.job_ready     (job_ready),
		.job           (job),
		.filtered_count(filtered_count)
	);

	////////////////////////////////////////////////////////////
	// memory model, ready generation and job counting
	////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		if (rstn) begin
			cycle_count = cycle_count + 1;
			rd_valid  <= 1'b0;
			cmd_ready <= (rand_below(4) != 0);
			// hold the compute unit off at first so the queue fills up
			if (cycle_count < STALL_CYCLES)
				job_ready <= 1'b0;
			else
				job_ready <= (rand_below(2) == 1);
			if (job_valid && job_ready)
				jobs_received = jobs_received + 1;
			if (cmd_valid && cmd_ready) begin
				pend_cmd.push_back(cmd);
				pend_due.push_back(cycle_count + rand_below(7));
			end
			// random pick gives out of order returns
			if (pend_cmd.size() != 0) begin
				pick = rand_below(pend_cmd.size());
				if (pend_due[pick] <= cycle_count) begin
					rd_valid <= 1'b1;
					rd_field <= pend_cmd[pick].field;
					rd_line  <= line_for(pend_cmd[pick]);
					pend_cmd.delete(pick);
					pend_due.delete(pick);
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// descriptor and end of run
	////////////////////////////////////////////////////////////

	initial begin
		seed          = 32'hfcb3;
		cycle_count   = 0;
		jobs_received = 0;
		pick          = 0;
		desc_valid    = 1'b0;
		desc          = '0;
		cmd_ready     = 1'b0;
		rd_valid      = 1'b0;
		rd_field      = vertex_job_pkg::OUT_DEGREE;
		rd_line       = '0;
		job_ready     = 1'b0;
		wait (rstn);
		@(posedge clock);
		desc_valid <= 1'b1;
		desc       <= '{NUM_VERTICES, OUT_BASE, EDGES_BASE, INV_BASE};
		@(posedge clock);
		while (!desc_ready)
			@(posedge clock);
		desc_valid <= 1'b0;
		wait (jobs_received == NUM_KEPT);
		@(posedge clock);
		if (filtered_count !== EXP_FILTERED) begin
			$display("Error: filtered_count 0x%h, expected 0x%h", filtered_count,
				EXP_FILTERED);
			$display("** FAIL **");
			$fatal(1, "filtered count mismatch");
		end else if (desc_ready !== 1'b1) begin
			// sequencer is back in idle once the last batch is sent
			$display("Error: desc_ready 0x%h, expected 0x%h", desc_ready, 1'b1);
			$display("** FAIL **");
			$fatal(1, "sequencer did not return to idle");
		end else begin
			$display("** PASS **");
			$finish;
		end
	end

	// first failed port check ends the run
	initial begin
		wait (DUT.u_assert.error_seen === 1'b1);
		$display("** FAIL **");
		$fatal(1, "port check failed");
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("watchdog expired before all jobs were received");
		$display("** FAIL **");
		$fatal(1, "timeout");
	end

endmodule

/* sim.f */
src/vertex_job_pkg.sv
src/vertex_read_sequencer.sv
src/vertex_line_unpacker.sv
src/vertex_job_queue.sv
src/vertex_job_control.sv
bench/vertex_job_assert.sv
bench/tb_clock_gen.sv
bench/tb_vertex_job_control.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module tb_vertex_job_control -f sim.f -o sim_vertex_job

./obj_dir/sim_vertex_job +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -qF '** FAIL **' sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -qF '** PASS **' sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
